//--- rtl/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

`define FETCH_XLEN      32
`define FETCH_RESET_PC  32'h1bfffffc    // seq pc after reset is 1c000000

`define VPPN_W          19
`define PPN_W           20
`define ECODE_W         6
`define ESUBCODE_W      9

`define ITLB_ENTRIES    4
`define PS_4M           6'd21           // anything else is a 4 KB page

`define ECODE_ADEF      6'h08           // fetch address error
`define ECODE_TLBR      6'h3f           // tlb refill
`define ECODE_PIF       6'h03           // page invalid on fetch
`define ECODE_PPI       6'h07           // page privilege illegal

`endif

//--- rtl/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    typedef union packed {
        struct packed {
            logic [2:0]         seg;        // window select
            logic [28:0]        offset;
        } dmw;
        struct packed {
            logic [`VPPN_W-1:0] vppn;
            logic               odd;        // bit 12, even/odd page
            logic [11:0]        offset;
        } tlb;
    } va_u;

    typedef struct packed {
        logic       plv0;                   // window usable at level 0
        logic       plv3;                   // window usable at level 3
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_cfg_s;

    typedef struct packed {
        logic               found;
        logic [`PPN_W-1:0]  ppn;
        logic [5:0]         ps;
        logic [1:0]         plv;
        logic               v;
    } tlb_result_s;

    typedef struct packed {
        logic [$clog2(`ITLB_ENTRIES)-1:0] idx;
        logic [`VPPN_W-1:0]               vppn;
        logic [5:0]                       ps;
        logic [`PPN_W-1:0]                ppn0;
        logic [1:0]                       plv0;
        logic                             v0;
        logic [`PPN_W-1:0]                ppn1;
        logic [1:0]                       plv1;
        logic                             v1;
    } tlb_fill_s;

    typedef struct packed {
        logic                   br_taken;
        logic [`FETCH_XLEN-1:0] br_target;
        logic                   br_stall;   // branch still resolving
    } redirect_s;

    typedef struct packed {
        logic [`FETCH_XLEN-1:0] inst;
        logic [`FETCH_XLEN-1:0] pc;
        logic                   excep_en;
        logic [`ECODE_W-1:0]    ecode;
        logic [`ESUBCODE_W-1:0] esubcode;
    } fetch_out_s;

    typedef struct packed {
        logic [`FETCH_XLEN-1:0] pa;
        logic                   excep_en;
        logic [`ECODE_W-1:0]    ecode;
    } xlate_s;

endpackage

//--- rtl/itlb.sv
`include "fetch_defines.svh"

module itlb (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   we,
    input  fetch_pkg::tlb_fill_s   fill,
    input  fetch_pkg::va_u         va,
    output fetch_pkg::tlb_result_s res
);

    fetch_pkg::tlb_fill_s      ent [`ITLB_ENTRIES];
    logic [`ITLB_ENTRIES-1:0]  ent_valid;
    logic [`ITLB_ENTRIES-1:0]  is_4m;
    logic [`ITLB_ENTRIES-1:0]  odd_sel;
    logic [`ITLB_ENTRIES-1:0]  hit;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ent_valid <= '0;
        end else if (we) begin
            ent_valid[fill.idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            ent[fill.idx] <= fill;
        end
    end

    // per-entry compare, 4M pages drop the low 9 vppn bits
    always_comb begin
        for (int i = 0; i < `ITLB_ENTRIES; i++) begin
            is_4m[i]   = (ent[i].ps == `PS_4M);
            odd_sel[i] = is_4m[i] ? va.tlb.vppn[8] : va.tlb.odd;    // va bit 21 or 12
            hit[i]     = ent_valid[i]
                         && (ent[i].vppn[18:9] == va.tlb.vppn[18:9])
                         && (is_4m[i] || (ent[i].vppn[8:0] == va.tlb.vppn[8:0]));
        end
    end

    // walk from the top so the lowest matching index is written last
    always_comb begin
        res = '0;
        for (int i = `ITLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                res.found = 1'b1;
                res.ps    = ent[i].ps;
                if (odd_sel[i]) begin
                    res.ppn = ent[i].ppn1;
                    res.plv = ent[i].plv1;
                    res.v   = ent[i].v1;
                end else begin
                    res.ppn = ent[i].ppn0;
                    res.plv = ent[i].plv0;
                    res.v   = ent[i].v0;
                end
            end
        end
    end

endmodule

//--- rtl/addr_xlate.sv
`include "fetch_defines.svh"

module addr_xlate (
    input  fetch_pkg::va_u         va,
    input  logic                   crmd_pg,
    input  logic [1:0]             crmd_plv,
    input  fetch_pkg::dmw_cfg_s    dmw0,
    input  fetch_pkg::dmw_cfg_s    dmw1,
    output fetch_pkg::va_u         tlb_va,
    input  fetch_pkg::tlb_result_s tlb_res,
    output fetch_pkg::xlate_s      xlate
);

    logic                   hit_dmw0;
    logic                   hit_dmw1;
    logic                   tlb_path;
    logic                   excep_adef;
    logic                   excep_tlbr;
    logic                   excep_pif;
    logic                   excep_ppi;
    logic [`FETCH_XLEN-1:0] pa;

    function automatic logic dmw_hit(input fetch_pkg::dmw_cfg_s cfg,
                                     input logic [1:0] plv,
                                     input logic [2:0] seg);
        return (cfg.vseg == seg)
               && (((plv == 2'd0) && cfg.plv0) || ((plv == 2'd3) && cfg.plv3));
    endfunction

    assign tlb_va   = va;
    assign hit_dmw0 = dmw_hit(dmw0, crmd_plv, va.dmw.seg);
    assign hit_dmw1 = dmw_hit(dmw1, crmd_plv, va.dmw.seg);
    assign tlb_path = crmd_pg & ~hit_dmw0 & ~hit_dmw1;     // mapped through the tlb

    always_comb begin
        if (!crmd_pg) begin
            pa = va;                                        // direct mode
        end else if (hit_dmw0) begin
            pa = {dmw0.pseg, va.dmw.offset};
        end else if (hit_dmw1) begin
            pa = {dmw1.pseg, va.dmw.offset};
        end else if (tlb_res.ps == `PS_4M) begin
            pa = {tlb_res.ppn[19:9], va.dmw.offset[20:0]};
        end else begin
            pa = {tlb_res.ppn, va.tlb.offset};
        end
    end

    assign excep_adef = |va.tlb.offset[1:0];
    assign excep_tlbr = tlb_path & ~tlb_res.found;
    assign excep_pif  = tlb_path & tlb_res.found & ~tlb_res.v;
    assign excep_ppi  = tlb_path & tlb_res.found & tlb_res.v & (crmd_plv > tlb_res.plv);

    assign xlate.pa       = pa;
    assign xlate.excep_en = excep_adef | excep_tlbr | excep_pif | excep_ppi;

    // first match wins
    always_comb begin
        if (excep_adef) begin
            xlate.ecode = `ECODE_ADEF;
        end else if (excep_tlbr) begin
            xlate.ecode = `ECODE_TLBR;
        end else if (excep_pif) begin
            xlate.ecode = `ECODE_PIF;
        end else if (excep_ppi) begin
            xlate.ecode = `ECODE_PPI;
        end else begin
            xlate.ecode = '0;
        end
    end

endmodule

//--- rtl/fetch_stage.sv
`include "fetch_defines.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   resetn,
    output logic                   inst_req,
    output logic [`FETCH_XLEN-1:0] inst_addr,
    input  logic                   inst_addr_ok,
    input  logic                   inst_data_ok,
    input  logic [`FETCH_XLEN-1:0] inst_rdata,
    input  logic                   id_allowin,
    input  fetch_pkg::redirect_s   redirect,
    input  logic                   flush,
    input  logic [`FETCH_XLEN-1:0] flush_entry,
    output logic                   if_valid,
    output fetch_pkg::fetch_out_s  if_out,
    output logic [`FETCH_XLEN-1:0] pre_pc,
    input  fetch_pkg::xlate_s      xlate
);

    logic                   fetch_en;
    logic                   pre_reqed;          // pre-IF request accepted, not yet in IF
    logic                   pre_ir_valid;
    logic [`FETCH_XLEN-1:0] pre_ir;
    logic [`FETCH_XLEN-1:0] pre_slot_pc;
    logic                   pre_excep_en;
    logic [`ECODE_W-1:0]    pre_ecode;
    logic                   if_full;            // IF holds a request, waiting or buffered
    logic                   if_ir_valid;
    logic [`FETCH_XLEN-1:0] if_ir;
    logic [`FETCH_XLEN-1:0] if_pc;
    logic                   if_excep_en;
    logic [`ECODE_W-1:0]    if_ecode;
    logic                   br_reg;
    logic [`FETCH_XLEN-1:0] br_target_reg;
    logic                   flush_reg;
    logic [`FETCH_XLEN-1:0] flush_entry_reg;
    logic [1:0]             cancel_cnt;         // wrong-path words still to come back
    logic [1:0]             n_out;
    logic [1:0]             n_left;
    logic                   kill;
    logic                   accept;
    logic                   if_wait;
    logic                   pre_wait;
    logic                   live_ok;
    logic                   data_to_if;
    logic                   data_to_pre;
    logic                   if_ready_go;
    logic                   if_allowin;
    logic                   enter_from_pre;
    logic                   enter_new;
    logic                   to_pre;
    logic [`FETCH_XLEN-1:0] seq_pc;

    assign kill     = flush | redirect.br_taken;
    assign accept   = inst_req & inst_addr_ok;
    assign if_wait  = if_full & ~if_ir_valid;
    assign pre_wait = pre_reqed & ~pre_ir_valid;
    assign n_out    = cancel_cnt + {1'b0, if_wait} + {1'b0, pre_wait};
    assign n_left   = n_out - {1'b0, inst_data_ok};    // still out after this cycle

    // returned words go to the cancelled ones first, they are the oldest
    assign live_ok     = inst_data_ok & (cancel_cnt == 2'd0);
    assign data_to_if  = live_ok & if_wait;
    assign data_to_pre = live_ok & ~if_wait & pre_wait;

    assign if_ready_go    = if_ir_valid | data_to_if;
    assign if_allowin     = ~if_full | (if_ready_go & id_allowin);
    assign enter_from_pre = ~kill & pre_reqed & if_allowin;
    assign enter_new      = accept & (kill | if_allowin);
    assign to_pre         = accept & ~kill & ~if_allowin;

    assign if_valid = if_ready_go & ~kill;         // IF content is wrong path on redirect

    assign inst_req  = fetch_en & ~pre_reqed & ~redirect.br_stall & (n_left < 2'd2);
    assign inst_addr = xlate.pa;

    assign seq_pc = if_pc + 32'd4;
    assign pre_pc = flush_reg          ? flush_entry_reg :
                    flush              ? flush_entry     :
                    br_reg             ? br_target_reg   :
                    redirect.br_taken  ? redirect.br_target :
                                         seq_pc;

    assign if_out.inst     = if_ir_valid ? if_ir : inst_rdata;
    assign if_out.pc       = if_pc;
    assign if_out.excep_en = if_excep_en;
    assign if_out.ecode    = if_ecode;
    assign if_out.esubcode = '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    // redirects wait here until a request to the target is accepted
    always_ff @(posedge clk) begin
        if (!resetn) begin
            flush_reg <= 1'b0;
            br_reg    <= 1'b0;
        end else begin
            if (accept) begin
                flush_reg <= 1'b0;
            end else if (flush) begin
                flush_reg <= 1'b1;
            end
            if (accept) begin
                br_reg <= 1'b0;
            end else if (redirect.br_taken) begin
                br_reg <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush && !accept) begin
            flush_entry_reg <= flush_entry;
        end
        if (redirect.br_taken && !accept) begin
            br_target_reg <= redirect.br_target;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_cnt <= 2'd0;
        end else if (kill) begin
            cancel_cnt <= n_left;                   // everything in flight is now stale
        end else if (inst_data_ok && (cancel_cnt != 2'd0)) begin
            cancel_cnt <= cancel_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_reqed    <= 1'b0;
            pre_ir_valid <= 1'b0;
        end else if (kill || enter_from_pre) begin
            pre_reqed    <= 1'b0;
            pre_ir_valid <= 1'b0;
        end else begin
            if (to_pre) begin
                pre_reqed <= 1'b1;
            end
            if (data_to_pre) begin
                pre_ir_valid <= 1'b1;               // IF still busy, park the word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (to_pre) begin
            pre_slot_pc  <= pre_pc;
            pre_excep_en <= xlate.excep_en;
            pre_ecode    <= xlate.ecode;
        end
        if (data_to_pre) begin
            pre_ir <= inst_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_full     <= 1'b0;
            if_ir_valid <= 1'b0;
        end else if (kill) begin
            if_full     <= accept;                  // only the redirect target survives
            if_ir_valid <= 1'b0;
        end else if (enter_from_pre) begin
            if_full     <= 1'b1;
            if_ir_valid <= pre_ir_valid | data_to_pre;
        end else if (if_allowin && accept) begin
            if_full     <= 1'b1;
            if_ir_valid <= 1'b0;
        end else if (if_ready_go && id_allowin) begin
            if_full     <= 1'b0;
            if_ir_valid <= 1'b0;
        end else if (data_to_if) begin
            if_ir_valid <= 1'b1;                    // decode stalled
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_pc <= `FETCH_RESET_PC;
        end else if (enter_from_pre) begin
            if_pc <= pre_slot_pc;
        end else if (enter_new) begin
            if_pc <= pre_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (enter_from_pre) begin
            if_excep_en <= pre_excep_en;
            if_ecode    <= pre_ecode;
            if_ir       <= pre_ir_valid ? pre_ir : inst_rdata;
        end else begin
            if (enter_new) begin
                if_excep_en <= xlate.excep_en;
                if_ecode    <= xlate.ecode;
            end
            if (data_to_if) begin
                if_ir <= inst_rdata;
            end
        end
    end

endmodule

//--- rtl/fetch_top.sv
`include "fetch_defines.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   resetn,
    output logic                   inst_req,
    output logic [`FETCH_XLEN-1:0] inst_addr,
    input  logic                   inst_addr_ok,
    input  logic                   inst_data_ok,
    input  logic [`FETCH_XLEN-1:0] inst_rdata,
    input  logic                   id_allowin,
    input  fetch_pkg::redirect_s   redirect,
    output logic                   if_valid,
    output fetch_pkg::fetch_out_s  if_out,
    input  logic                   flush,
    input  logic [`FETCH_XLEN-1:0] flush_entry,
    input  logic                   crmd_pg,
    input  logic [1:0]             crmd_plv,
    input  fetch_pkg::dmw_cfg_s    dmw0,
    input  fetch_pkg::dmw_cfg_s    dmw1,
    input  logic                   tlb_we,
    input  fetch_pkg::tlb_fill_s   tlb_fill
);

    logic [`FETCH_XLEN-1:0] pre_pc;     // virtual pc of the next request
    fetch_pkg::va_u         tlb_va;
    fetch_pkg::tlb_result_s tlb_res;
    fetch_pkg::xlate_s      xlate;

    fetch_stage u_fetch_stage (
        .clk          (clk),
        .resetn       (resetn),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .id_allowin   (id_allowin),
        .redirect     (redirect),
        .flush        (flush),
        .flush_entry  (flush_entry),
        .if_valid     (if_valid),
        .if_out       (if_out),
        .pre_pc       (pre_pc),
        .xlate        (xlate)
    );

    addr_xlate u_addr_xlate (
        .va       (pre_pc),
        .crmd_pg  (crmd_pg),
        .crmd_plv (crmd_plv),
        .dmw0     (dmw0),
        .dmw1     (dmw1),
        .tlb_va   (tlb_va),
        .tlb_res  (tlb_res),
        .xlate    (xlate)
    );

    itlb u_itlb (
        .clk    (clk),
        .resetn (resetn),
        .we     (tlb_we),
        .fill   (tlb_fill),
        .va     (tlb_va),
        .res    (tlb_res)
    );

endmodule

//--- test/fetch_chk.sv
module fetch_chk (
    input logic                  clk,
    input logic                  resetn,
    input logic                  inst_req,
    input logic                  inst_addr_ok,
    input logic                  inst_data_ok,
    input logic                  id_allowin,
    input fetch_pkg::redirect_s  redirect,
    input logic                  flush,
    input logic                  if_valid,
    input fetch_pkg::fetch_out_s if_out
);

    logic [2:0] outstanding;    // accepted requests without data_ok yet
    int         fails = 0;      // assertion failures so far

    always_ff @(posedge clk) begin
        if (!resetn) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 3'(inst_req && inst_addr_ok) - 3'(inst_data_ok);
        end
    end

    // only a redirect may drop a stalled instruction
    stall_hold: assert property (@(posedge clk) disable iff (!resetn)
        (if_valid && !id_allowin)
        |=> ((if_valid || flush || redirect.br_taken) && $stable(if_out)))
        else begin
            fails++;
            $error("if_out changed or if_valid dropped while decode was stalled");
        end

    no_req_in_reset: assert property (@(posedge clk)
        ($past(!resetn) && !resetn) |-> !inst_req)
        else begin
            fails++;
            $error("inst_req high during reset");
        end

    max_outstanding: assert property (@(posedge clk) disable iff (!resetn)
        outstanding <= 3'd2)
        else begin
            fails++;
            $error("more than two requests outstanding");
        end

endmodule

//--- test/fetch_scoreboard.sv
`include "fetch_defines.svh"

module fetch_scoreboard (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  if_valid,
    input  logic                  id_allowin,
    input  fetch_pkg::fetch_out_s if_out,
    input  logic                  flush,
    input  logic [31:0]           flush_entry,
    input  fetch_pkg::redirect_s  redirect,
    input  logic                  crmd_pg,
    input  logic [1:0]            crmd_plv,
    input  fetch_pkg::dmw_cfg_s   dmw0,
    input  fetch_pkg::dmw_cfg_s   dmw1,
    input  logic                  tlb_we,
    input  fetch_pkg::tlb_fill_s  tlb_fill,
    input  logic                  done,
    output int                    errors
);

    fetch_pkg::tlb_fill_s shadow;       // model of tlb entry 0
    logic                 shadow_ok;
    logic [31:0]          exp_pc;
    int                   test_no;
    int                   test_insts;
    int                   test_errs;
    int                   checks;
    logic                 reported;

    function automatic logic window_ok(input fetch_pkg::dmw_cfg_s c, input logic [31:0] va);
        return (c.vseg == va[31:29])
               && ((crmd_plv == 2'd0 && c.plv0) || (crmd_plv == 2'd3 && c.plv3));
    endfunction

    function automatic fetch_pkg::xlate_s predict(input logic [31:0] va);
        fetch_pkg::xlate_s r;
        logic              mapped;
        logic              big;
        logic              hit;
        logic              odd;
        logic [19:0]       ppn;
        r      = '0;
        mapped = crmd_pg && !window_ok(dmw0, va) && !window_ok(dmw1, va);
        big    = (shadow.ps == `PS_4M);
        hit    = shadow_ok && (big ? (shadow.vppn[18:9] == va[31:22])
                                   : (shadow.vppn == va[31:13]));
        odd    = big ? va[21] : va[12];
        ppn    = odd ? shadow.ppn1 : shadow.ppn0;
        if (!crmd_pg) begin
            r.pa = va;
        end else if (window_ok(dmw0, va)) begin
            r.pa = {dmw0.pseg, va[28:0]};
        end else if (window_ok(dmw1, va)) begin
            r.pa = {dmw1.pseg, va[28:0]};
        end else begin
            r.pa = big ? {ppn[19:9], va[20:0]} : {ppn, va[11:0]};
        end
        r.excep_en = 1'b1;
        if (va[1:0] != 2'b00) begin
            r.ecode = `ECODE_ADEF;
        end else if (mapped && !hit) begin
            r.ecode = `ECODE_TLBR;
        end else if (mapped && !(odd ? shadow.v1 : shadow.v0)) begin
            r.ecode = `ECODE_PIF;
        end else if (mapped && crmd_plv > (odd ? shadow.plv1 : shadow.plv0)) begin
            r.ecode = `ECODE_PPI;
        end else begin
            r.excep_en = 1'b0;
        end
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("ERR %s exp %h got %h", name, exp, got);
            errors++;
            test_errs++;
        end
    endtask

    task automatic close_test();
        if (test_insts == 0) begin
            $display("test %0d delivered no instructions", test_no);
            errors++;
        end else begin
            $display("test %0d: %0d instructions checked, %0d errors",
                     test_no, test_insts, test_errs);
        end
    endtask

    always @(negedge clk) begin
        fetch_pkg::xlate_s e;
        if (!resetn) begin
            shadow_ok = 1'b0;
            errors    = 0;
            test_no   = 0;
            checks    = 0;
            reported  = 1'b0;
        end else begin
            if (tlb_we) begin
                shadow    = tlb_fill;
                shadow_ok = 1'b1;
            end
            if (flush) begin
                if (test_no > 0) close_test();
                test_no++;
                test_insts = 0;
                test_errs  = 0;
                exp_pc     = flush_entry;
            end else if (redirect.br_taken) begin
                exp_pc = redirect.br_target;
            end else if (if_valid && id_allowin) begin
                if (test_no == 0) begin
                    $display("instruction delivered before the first test started");
                    errors++;
                end else begin
                    e = predict(exp_pc);
                    checks++;
                    test_insts++;
                    compare("if_out.pc", exp_pc, if_out.pc);
                    compare("if_out.excep_en", 32'(e.excep_en), 32'(if_out.excep_en));
                    compare("if_out.ecode", 32'(e.ecode), 32'(if_out.ecode));
                    compare("if_out.esubcode", 32'h0, 32'(if_out.esubcode));
                    if (!e.excep_en) compare("if_out.inst", ~e.pa, if_out.inst);
                    exp_pc = exp_pc + 32'd4;
                end
            end
            if (done && !reported) begin
                if (test_no > 0) close_test();
                $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
                reported = 1'b1;
            end
        end
    end

endmodule

//--- test/fetch_tb.sv
module fetch_tb;

    localparam int MAX_TESTS = 16;

    typedef struct {
        logic        pg;
        logic [1:0]  plv;
        logic [7:0]  dmw0;
        logic [7:0]  dmw1;
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic [19:0] ppn0;
        logic [1:0]  plv0;
        logic        v0;
        logic [19:0] ppn1;
        logic [1:0]  plv1;
        logic        v1;
        logic [31:0] start;
        int          br_after;
        logic [31:0] br_target;
        int          count;
    } test_t;

    logic                  clk = 1'b0;
    logic                  resetn;
    logic                  inst_req;
    logic [31:0]           inst_addr;
    logic                  inst_addr_ok = 1'b0;
    logic                  inst_data_ok = 1'b0;
    logic [31:0]           inst_rdata = '0;
    logic                  id_allowin;
    fetch_pkg::redirect_s  redirect;
    logic                  if_valid;
    fetch_pkg::fetch_out_s if_out;
    logic                  flush;
    logic [31:0]           flush_entry;
    logic                  crmd_pg;
    logic [1:0]            crmd_plv;
    fetch_pkg::dmw_cfg_s   dmw0;
    fetch_pkg::dmw_cfg_s   dmw1;
    logic                  tlb_we;
    fetch_pkg::tlb_fill_s  tlb_fill;
    logic                  done;
    int                    sb_errors;
    test_t                 tests [MAX_TESTS];
    int                    n_tests;
    int                    limit = 0;
    int                    cyc = 0;
    logic [15:0]           mem_lfsr = 16'd65522;
    logic [15:0]           dec_lfsr = 16'd65522;
    logic [31:0]           pend_addr [$];
    int                    pend_due [$];

    fetch_top DUT (.*);

    fetch_scoreboard u_scoreboard (.*, .errors(sb_errors));

    bind fetch_top fetch_chk u_chk (.*);

    always #10 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic int mem_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v        = (v << 1) | mem_lfsr[0];
            mem_lfsr = lfsr_step(mem_lfsr);
        end
        return v;
    endfunction

    function automatic int dec_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v        = (v << 1) | dec_lfsr[0];
            dec_lfsr = lfsr_step(dec_lfsr);
        end
        return v;
    endfunction

    // in-order memory model returning each word 1 to 4 cycles after acceptance
    always @(negedge clk) begin
        if (resetn && inst_req && inst_addr_ok) begin
            pend_addr.push_back(inst_addr);
            pend_due.push_back(cyc + 1 + mem_bits(2));
        end
        if (inst_data_ok) begin
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        #1;
        inst_addr_ok = mem_bits(1) != 0;
        if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
            inst_data_ok = 1'b1;
            inst_rdata   = ~pend_addr[0];   // word tells which pa was read
        end else begin
            inst_data_ok = 1'b0;
        end
    end

    task automatic run_test(input test_t t);
        int   delivered;
        logic took;
        @(posedge clk);
        #1;
        crmd_pg        = t.pg;
        crmd_plv       = t.plv;
        dmw0           = t.dmw0;
        dmw1           = t.dmw1;
        tlb_fill.idx   = '0;
        tlb_fill.vppn  = t.vppn;
        tlb_fill.ps    = t.ps;
        tlb_fill.ppn0  = t.ppn0;
        tlb_fill.plv0  = t.plv0;
        tlb_fill.v0    = t.v0;
        tlb_fill.ppn1  = t.ppn1;
        tlb_fill.plv1  = t.plv1;
        tlb_fill.v1    = t.v1;
        tlb_we         = 1'b1;
        @(posedge clk);
        #1;
        tlb_we             = 1'b0;
        flush              = 1'b1;
        flush_entry        = t.start;
        redirect.br_taken  = 1'b1;              // a stale branch that the flush overrides
        redirect.br_target = t.br_target;
        @(posedge clk);
        #1;
        flush             = 1'b0;
        redirect.br_taken = 1'b0;
        delivered         = 0;
        while (delivered < t.count) begin
            id_allowin = dec_bits(2) != 0;
            @(negedge clk);
            took = if_valid && id_allowin;
            @(posedge clk);
            #1;
            if (took) begin
                delivered++;
                if (delivered == t.br_after && delivered < t.count) begin
                    redirect.br_taken  = 1'b1;  // decode resolves the branch
                    redirect.br_target = t.br_target;
                    @(posedge clk);
                    #1;
                    redirect.br_taken = 1'b0;
                end
            end
        end
        id_allowin = 1'b0;                      // hold the rest until the next flush
    endtask

    initial begin
        int    fd;
        string line;
        test_t t;
        int    total;
        logic  file_error;
        resetn      = 1'b0;
        id_allowin  = 1'b0;
        redirect    = '0;
        flush       = 1'b0;
        flush_entry = '0;
        crmd_pg     = 1'b0;
        crmd_plv    = '0;
        dmw0        = '0;
        dmw1        = '0;
        tlb_we      = 1'b0;
        tlb_fill    = '0;
        done        = 1'b0;
        n_tests     = 0;
        total       = 0;
        file_error  = 1'b0;
        fd = $fopen("test/fetch_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/fetch_golden.txt");
            file_error = 1'b1;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#" && n_tests < MAX_TESTS) begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                t.pg, t.plv, t.dmw0, t.dmw1, t.vppn, t.ps, t.ppn0, t.plv0,
                                t.v0, t.ppn1, t.plv1, t.v1, t.start, t.br_after,
                                t.br_target, t.count) == 16) begin
                        tests[n_tests] = t;
                        total          = total + t.count + 1;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
        limit = total * 20 * 20;               // 20 cycles per instruction and per test
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            run_test(tests[i]);
        end
        done = 1'b1;
        repeat (2) @(posedge clk);
        if (!file_error && n_tests > 0 && sb_errors == 0 && DUT.u_chk.fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (limit > 0);
        #(limit);
        $display("watchdog expired after %0d time units, fetch stopped delivering", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- test/fetch_golden.txt
# pg plv dmw0 dmw1 vppn ps ppn0 plv0 v0 ppn1 plv1 v1 start br_after br_target count
# all columns hex, the tlb entry goes to index 0, br_after 0 means no branch
0 0 00 00 00000 0c 00000 0 0 00000 0 0 1c000000 0 00000000 c
0 0 00 00 00000 0c 00000 0 0 00000 0 0 1c000100 5 1c000800 a
1 0 85 00 00000 0c 00000 0 0 00000 0 0 a0001000 0 00000000 8
1 3 85 4c 50001 0c 00123 3 1 00456 3 1 a0002ff0 0 00000000 8
1 3 00 4c 50001 0c 00123 3 1 00456 3 1 80000040 3 80000400 6
1 0 00 00 00200 15 00800 0 1 00c00 0 1 005ffff8 0 00000000 6
0 0 00 00 00200 15 00800 0 1 00c00 0 1 1c000002 0 00000000 4
1 0 00 00 00200 15 00800 0 1 00c00 0 1 00010000 0 00000000 4
1 0 00 00 00008 0c 00077 0 0 00078 0 0 00010000 0 00000000 4
1 3 00 00 00008 0c 00077 0 1 00078 0 1 00010000 0 00000000 4

//--- build.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/itlb.sv
rtl/addr_xlate.sv
rtl/fetch_stage.sv
rtl/fetch_top.sv
test/fetch_chk.sv
test/fetch_scoreboard.sv
test/fetch_tb.sv

//--- Makefile
TOP := fetch_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
